/* hdl/usb_echo_pkg.sv */
package usb_echo_pkg;

  // One byte of USB bulk payload
  typedef logic [7:0] byte_t;

  // Status bits from the USB core, shown on the LEDs
  typedef logic [3:0] status_t;

  // Board LED vector
  typedef logic [5:0] led_t;

  // Low LEDs with no status bit behind them stay high (off)
  localparam int LED_UNUSED_COUNT = 2;

  // Bulk IN is flagged ready while the FIFO holds more than this
  localparam int IN_LEVEL_MIN = 4;

  // Bulk OUT is flagged ready while the FIFO holds fewer than this
  localparam int OUT_LEVEL_MAX = 1024;

  // Read-side prefetch stage of the packet FIFO
  //   RD_EMPTY  nothing in the RAM read register
  //   RD_FETCH  a read was issued last cycle and RAM output is fresh
  //   RD_HOLD   RAM output is valid but waits for the output register
  typedef enum logic [1:0] {
    RD_EMPTY,
    RD_FETCH,
    RD_HOLD
  } fifo_rd_state_t;

endpackage

/* hdl/packet_fifo_ram.sv */
`timescale 1ns/10ps
module packet_fifo_ram #(
  parameter int DEPTH = 2048
) (
  input  logic                     clock,
  input  logic                     wr_en_i,
  input  logic [$clog2(DEPTH)-1:0] wr_addr_i,
  input  logic [8:0]               wr_data_i,
  input  logic                     rd_en_i,
  input  logic [$clog2(DEPTH)-1:0] rd_addr_i,
  output logic [8:0]               rd_data_o
);

  localparam int ABITS = $clog2(DEPTH);

  // Each word holds the last flag above the payload byte
  logic [8:0] mem [DEPTH];

  logic [ABITS-1:0] wr_addr;
  logic [ABITS-1:0] rd_addr;

  assign wr_addr = wr_addr_i;
  assign rd_addr = rd_addr_i;

  always_ff @(posedge clock) begin
    if (wr_en_i) begin
      mem[wr_addr] <= wr_data_i;
    end
  end

  // Registered read port whose output holds while rd_en_i is low
  always_ff @(posedge clock) begin
    if (rd_en_i) begin
      rd_data_o <= mem[rd_addr];
    end
  end

endmodule

/* hdl/packet_fifo.sv */
`timescale 1ns/10ps
module packet_fifo #(
  parameter int DEPTH = 2048
) (
  input  logic                       clock,
  input  logic                       reset,

  input  logic                       s_valid_i,
  output logic                       s_ready_o,
  input  logic                       s_last_i,
  input  usb_echo_pkg::byte_t        s_data_i,

  output logic                       m_valid_o,
  input  logic                       m_ready_i,
  output logic                       m_last_o,
  output usb_echo_pkg::byte_t        m_data_o,

  output logic [$clog2(DEPTH+1)-1:0] level_o
);

  // Pointers carry one wrap bit above the address of a power-of-two DEPTH
  localparam int ABITS = $clog2(DEPTH);
  localparam int LBITS = $clog2(DEPTH + 1);

  logic [ABITS:0] wr_ptr;
  logic [ABITS:0] commit_ptr;
  logic [ABITS:0] rd_ptr;
  logic [LBITS-1:0] level;

  logic push;
  logic pop;
  logic avail;
  logic stage_valid;
  logic out_free;
  logic load_out;
  logic stage_free;
  logic issue;

  logic [8:0] ram_wr_data;
  logic [8:0] ram_rd_data;

  usb_echo_pkg::fifo_rd_state_t rd_state;

  // Level covers every byte not yet consumed so the RAM cannot overflow
  assign s_ready_o = (level != LBITS'(DEPTH));
  assign push      = s_valid_i & s_ready_o;
  assign pop       = m_valid_o & m_ready_i;
  assign level_o   = level;

  assign ram_wr_data = {s_last_i, s_data_i};

  // Only bytes of completed packets are visible to the read side
  assign avail = (commit_ptr != rd_ptr);

  assign stage_valid = (rd_state != usb_echo_pkg::RD_EMPTY);
  assign out_free    = ~m_valid_o | pop;
  assign load_out    = stage_valid & out_free;
  assign stage_free  = ~stage_valid | load_out;
  assign issue       = avail & stage_free;

  packet_fifo_ram #(
    .DEPTH(DEPTH)
  ) u_packet_fifo_ram (
    .clock    (clock),
    .wr_en_i  (push),
    .wr_addr_i(wr_ptr[ABITS-1:0]),
    .wr_data_i(ram_wr_data),
    .rd_en_i  (issue),
    .rd_addr_i(rd_ptr[ABITS-1:0]),
    .rd_data_o(ram_rd_data)
  );

  // Write and commit pointers
  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr     <= '0;
      commit_ptr <= '0;
    end else if (push) begin
      wr_ptr <= wr_ptr + 1'b1;
      if (s_last_i) begin
        commit_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      level <= '0;
    end else if (push && !pop) begin
      level <= level + 1'b1;
    end else if (!push && pop) begin
      level <= level - 1'b1;
    end
  end

  // Prefetch of the RAM read stage
  always_ff @(posedge clock) begin
    if (reset) begin
      rd_ptr   <= '0;
      rd_state <= usb_echo_pkg::RD_EMPTY;
    end else begin
      if (issue) begin
        rd_ptr   <= rd_ptr + 1'b1;
        rd_state <= usb_echo_pkg::RD_FETCH;
      end else if (stage_valid && !load_out) begin
        rd_state <= usb_echo_pkg::RD_HOLD;
      end else begin
        rd_state <= usb_echo_pkg::RD_EMPTY;
      end
    end
  end

  // Output register valid
  always_ff @(posedge clock) begin
    if (reset) begin
      m_valid_o <= 1'b0;
    end else if (load_out) begin
      m_valid_o <= 1'b1;
    end else if (pop) begin
      m_valid_o <= 1'b0;
    end
  end

  // Output payload, loaded from the RAM read register
  always_ff @(posedge clock) begin
    if (load_out) begin
      m_last_o <= ram_rd_data[8];
      m_data_o <= ram_rd_data[7:0];
    end
  end

endmodule

/* hdl/endpoint_status.sv */
`timescale 1ns/10ps
module endpoint_status #(
  parameter int DEPTH = 2048
) (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       configured_i,
  input  logic [$clog2(DEPTH+1)-1:0] level_i,
  input  usb_echo_pkg::status_t      status_i,
  output logic                       bulk_in_ready_o,
  output logic                       bulk_out_ready_o,
  output usb_echo_pkg::led_t         leds_o
);

  localparam int LBITS = $clog2(DEPTH + 1);

  logic in_level_ok;
  logic out_level_ok;

  assign in_level_ok  = (level_i > LBITS'(usb_echo_pkg::IN_LEVEL_MIN));
  assign out_level_ok = (level_i < LBITS'(usb_echo_pkg::OUT_LEVEL_MAX));

  // Endpoint flags only rise once the device is configured
  always_ff @(posedge clock) begin
    if (reset) begin
      bulk_in_ready_o  <= 1'b0;
      bulk_out_ready_o <= 1'b0;
    end else begin
      bulk_in_ready_o  <= configured_i & in_level_ok;
      bulk_out_ready_o <= configured_i & out_level_ok;
    end
  end

  // LEDs are active low and the unused ones stay dark
  assign leds_o = {~status_i, {usb_echo_pkg::LED_UNUSED_COUNT{1'b1}}};

endmodule

/* hdl/usb_echo_top.sv */
`timescale 1ns/10ps
module usb_echo_top #(
  parameter int FIFO_DEPTH = 2048
) (
  input  logic                  clock,
  input  logic                  reset,

  // From the USB core
  input  logic                  configured_i,
  input  usb_echo_pkg::status_t status_i,

  // Bulk OUT stream from the host
  input  logic                  out_valid_i,
  output logic                  out_ready_o,
  input  logic                  out_last_i,
  input  usb_echo_pkg::byte_t   out_data_i,

  // Bulk IN stream to the host
  output logic                  in_valid_o,
  input  logic                  in_ready_i,
  output logic                  in_last_o,
  output usb_echo_pkg::byte_t   in_data_o,

  // Endpoint flags back to the USB core
  output logic                  bulk_in_ready_o,
  output logic                  bulk_out_ready_o,

  output usb_echo_pkg::led_t    leds_o
);

  localparam int LBITS = $clog2(FIFO_DEPTH + 1);

  logic [LBITS-1:0] fifo_level;

  // Whole packets from OUT are echoed back on IN
  packet_fifo #(
    .DEPTH(FIFO_DEPTH)
  ) u_packet_fifo (
    .clock    (clock),
    .reset    (reset),
    .s_valid_i(out_valid_i),
    .s_ready_o(out_ready_o),
    .s_last_i (out_last_i),
    .s_data_i (out_data_i),
    .m_valid_o(in_valid_o),
    .m_ready_i(in_ready_i),
    .m_last_o (in_last_o),
    .m_data_o (in_data_o),
    .level_o  (fifo_level)
  );

  endpoint_status #(
    .DEPTH(FIFO_DEPTH)
  ) u_endpoint_status (
    .clock           (clock),
    .reset           (reset),
    .configured_i    (configured_i),
    .level_i         (fifo_level),
    .status_i        (status_i),
    .bulk_in_ready_o (bulk_in_ready_o),
    .bulk_out_ready_o(bulk_out_ready_o),
    .leds_o          (leds_o)
  );

endmodule

/* tb/tb_usb_echo.sv */
`timescale 1ns/10ps
module tb_usb_echo;

  localparam int FIFO_DEPTH = 2048;
  localparam int CYCLE_LIMIT = 20000;

  logic                  clock;
  logic                  reset;
  logic                  configured_i;
  usb_echo_pkg::status_t status_i;
  logic                  out_valid_i;
  logic                  out_ready_o;
  logic                  out_last_i;
  usb_echo_pkg::byte_t   out_data_i;
  logic                  in_valid_o;
  logic                  in_ready_i;
  logic                  in_last_o;
  usb_echo_pkg::byte_t   in_data_o;
  logic                  bulk_in_ready_o;
  logic                  bulk_out_ready_o;
  usb_echo_pkg::led_t    leds_o;

  integer     seed;
  int         errors;
  int         sent_count;
  int         received_count;
  int         accepted_count;
  int         model_level;
  int         cycle_count;
  int         in_ready_mode;
  logic       exp_in_flag;
  logic       exp_out_flag;
  logic [8:0] exp_word;
  logic [8:0] exp_q[$];

  usb_echo_top #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_usb_echo_top (
    .clock           (clock),
    .reset           (reset),
    .configured_i    (configured_i),
    .status_i        (status_i),
    .out_valid_i     (out_valid_i),
    .out_ready_o     (out_ready_o),
    .out_last_i      (out_last_i),
    .out_data_i      (out_data_i),
    .in_valid_o      (in_valid_o),
    .in_ready_i      (in_ready_i),
    .in_last_o       (in_last_o),
    .in_data_o       (in_data_o),
    .bulk_in_ready_o (bulk_in_ready_o),
    .bulk_out_ready_o(bulk_out_ready_o),
    .leds_o          (leds_o)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // Expected IN word carries the same byte with last set on the final one
  function automatic logic [8:0] expected_word(input usb_echo_pkg::byte_t data,
                                               input int idx, input int len);
    return {(idx == len - 1), data};
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'({$random(seed)} % (hi - lo + 1));
  endfunction

  // IN consumer mode 0 stalls, 1 is always ready and 2 stalls at random
  initial begin
    in_ready_i = 1'b0;
    forever begin
      @(posedge clock);
      #2;
      case (in_ready_mode)
        0:       in_ready_i = 1'b0;
        1:       in_ready_i = 1'b1;
        default: in_ready_i = ({$random(seed)} % 4) != 0;
      endcase
    end
  end

  // Compare every IN transfer with the next expected word
  always @(posedge clock) begin
    if (!reset && in_valid_o && in_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("IN stream delivered a byte with nothing expected at %0t", $time);
        errors = errors + 1;
      end else begin
        exp_word = exp_q.pop_front();
        if (in_data_o !== exp_word[7:0]) begin
          $display("mismatch at %0t: in_data_o expected %h, got %h",
                   $time, exp_word[7:0], in_data_o);
          errors = errors + 1;
        end
        if (in_last_o !== exp_word[8]) begin
          $display("mismatch at %0t: in_last_o expected %b, got %b",
                   $time, exp_word[8], in_last_o);
          errors = errors + 1;
        end
        received_count = received_count + 1;
      end
    end
  end

  // Level model with the registered endpoint flags and the full flag
  always @(posedge clock) begin
    if (reset) begin
      model_level  = 0;
      exp_in_flag  = 1'b0;
      exp_out_flag = 1'b0;
    end else begin
      if (bulk_in_ready_o !== exp_in_flag) begin
        $display("mismatch at %0t: bulk_in_ready_o expected %b, got %b",
                 $time, exp_in_flag, bulk_in_ready_o);
        errors = errors + 1;
      end
      if (bulk_out_ready_o !== exp_out_flag) begin
        $display("mismatch at %0t: bulk_out_ready_o expected %b, got %b",
                 $time, exp_out_flag, bulk_out_ready_o);
        errors = errors + 1;
      end
      if (out_ready_o !== (model_level != FIFO_DEPTH)) begin
        $display("mismatch at %0t: out_ready_o expected %b, got %b",
                 $time, (model_level != FIFO_DEPTH), out_ready_o);
        errors = errors + 1;
      end
      exp_in_flag  = configured_i && (model_level > usb_echo_pkg::IN_LEVEL_MIN);
      exp_out_flag = configured_i && (model_level < usb_echo_pkg::OUT_LEVEL_MAX);
      if (out_valid_i && out_ready_o) begin
        accepted_count = accepted_count + 1;
        model_level    = model_level + 1;
      end
      if (in_valid_o && in_ready_i) begin
        model_level = model_level - 1;
      end
    end
  end

  // Called just after a rising edge and returns just after the edge that took the byte
  task automatic send_byte(input usb_echo_pkg::byte_t data, input logic last);
    out_valid_i = 1'b1;
    out_data_i  = data;
    out_last_i  = last;
    @(posedge clock);
    while (!out_ready_o) begin
      @(posedge clock);
    end
    #2;
    out_valid_i = 1'b0;
    out_last_i  = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clock);
      #2;
    end
  endtask

  // Holds back the last byte and watches that nothing leaves meanwhile
  task automatic hold_and_check(input int n);
    repeat (n) begin
      @(posedge clock);
      if (in_valid_o) begin
        $display("in_valid_o rose at %0t before the packet's last byte was sent", $time);
        errors = errors + 1;
      end
      #2;
    end
  endtask

  task automatic send_packet(input int len, input int hold_cycles);
    usb_echo_pkg::byte_t pkt [64];
    int i;
    for (i = 0; i < len; i++) begin
      pkt[i] = usb_echo_pkg::byte_t'($random(seed));
      exp_q.push_back(expected_word(pkt[i], i, len));
    end
    for (i = 0; i < len; i++) begin
      if (i == len - 1) begin
        hold_and_check(hold_cycles);
      end
      send_byte(pkt[i], i == len - 1);
    end
    sent_count = sent_count + len;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clock);
    end
    @(posedge clock);
    #2;
  endtask

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clock);
      cycle_count = cycle_count + 1;
    end
    $display("timeout: IN stream did not drain");
    $display("errors: %0d, bytes sent: %0d, bytes received: %0d",
             errors, sent_count, received_count);
    $display("Checks failed");
    $finish;
  end

  initial begin
    seed           = 39;
    errors         = 0;
    sent_count     = 0;
    received_count = 0;
    accepted_count = 0;
    in_ready_mode  = 1;
    reset          = 1'b1;
    configured_i   = 1'b0;
    status_i       = '0;
    out_valid_i    = 1'b0;
    out_last_i     = 1'b0;
    out_data_i     = '0;
    repeat (4) @(posedge clock);
    #2;
    reset = 1'b0;

    if (in_valid_o || bulk_in_ready_o || bulk_out_ready_o || !out_ready_o) begin
      $display("outputs not in their reset state after reset at %0t", $time);
      errors = errors + 1;
    end

    // Endpoint flags stay low during traffic while not configured
    in_ready_mode = 2;
    repeat (5) begin
      send_packet(rand_range(1, 40), 0);
      if (bulk_in_ready_o || bulk_out_ready_o) begin
        $display("endpoint flag high at %0t while not configured", $time);
        errors = errors + 1;
      end
    end
    wait_drain();
    configured_i = 1'b1;
    idle_cycles(2);

    // Random loopback with random consumer stalls
    repeat (40) begin
      send_packet(rand_range(1, 40), 0);
      idle_cycles(rand_range(0, 3));
    end
    wait_drain();

    // IN stays quiet until the last byte of a held packet
    in_ready_mode = 1;
    idle_cycles(2);
    send_packet(10, 20);
    wait_drain();

    // Fill to full with IN stalled and release afterwards
    in_ready_mode = 0;
    idle_cycles(2);
    fork
      begin
        repeat (70) send_packet(30, 0);
      end
      begin
        wait (accepted_count - received_count == FIFO_DEPTH);
        @(posedge clock);
        #2;
        idle_cycles(10);
        if (out_ready_o || bulk_out_ready_o) begin
          $display("OUT side still ready at %0t with the FIFO full", $time);
          errors = errors + 1;
        end
        in_ready_mode = 1;
      end
    join
    wait_drain();

    // bulk_in_ready_o follows the level around the threshold
    in_ready_mode = 0;
    idle_cycles(2);
    send_packet(6, 0);
    idle_cycles(3);
    if (!bulk_in_ready_o) begin
      $display("bulk_in_ready_o low at %0t with 6 bytes stored", $time);
      errors = errors + 1;
    end
    in_ready_mode = 1;
    wait_drain();
    idle_cycles(3);
    if (bulk_in_ready_o || !bulk_out_ready_o) begin
      $display("endpoint flags wrong at %0t with the FIFO empty", $time);
      errors = errors + 1;
    end

    // LEDs show the inverted status above two dark LEDs
    repeat (16) begin
      status_i = usb_echo_pkg::status_t'($random(seed));
      @(posedge clock);
      if (leds_o !== {~status_i, 2'b11}) begin
        $display("mismatch at %0t: leds_o expected %b, got %b",
                 $time, {~status_i, 2'b11}, leds_o);
        errors = errors + 1;
      end
      #2;
    end

    if (exp_q.size() != 0 || received_count != sent_count) begin
      $display("IN stream delivered %0d bytes but %0d were sent", received_count, sent_count);
      errors = errors + 1;
    end
    $display("errors: %0d, bytes sent: %0d, bytes received: %0d",
             errors, sent_count, received_count);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* compile.f */
hdl/usb_echo_pkg.sv
hdl/packet_fifo_ram.sv
hdl/packet_fifo.sv
hdl/endpoint_status.sv
hdl/usb_echo_top.sv
tb/tb_usb_echo.sv

/* sim.sh */
#!/bin/sh
# Build and run the USB echo testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps \
  -f compile.f --top-module tb_usb_echo -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vtb_usb_echo)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "All checks passed"; then
  exit 0
else
  exit 1
fi
